// File: sw_pkg.sv
package sw_pkg;

    localparam int SCORE_W = 14;
    localparam int POS_W   = 10;

    typedef logic signed [SCORE_W-1:0] score_t;

    // most negative score, also the saturation floor
    localparam score_t NEG_INF        = 14'b11_0000_0000_0000;
    localparam score_t MATCH_SCORE    = 14'sd2;
    localparam score_t MISMATCH_SCORE = -14'sd3;
    localparam score_t GAP_OPEN       = -14'sd12;
    localparam score_t GAP_EXT        = -14'sd1;

    typedef enum logic [1:0] {
        BASE_A,
        BASE_C,
        BASE_G,
        BASE_T
    } base_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_CALC,
        ST_DONE
    } ctrl_state_e;

    // signed add clamped at NEG_INF
    function automatic score_t sat_add(score_t a, score_t b);
        logic signed [SCORE_W:0] sum;
        sum = a + b;
        if (sum < NEG_INF) begin
            return NEG_INF;
        end
        return score_t'(sum[SCORE_W-1:0]);
    endfunction

    function automatic score_t smax(score_t a, score_t b);
        return (a >= b) ? a : b;
    endfunction

endpackage

// File: sw_pe.sv
module sw_pe (
    input  sw_pkg::base_e  i_q_base,
    input  sw_pkg::base_e  i_r_base,
    input  sw_pkg::score_t i_h_diag,
    input  sw_pkg::score_t i_h_top,
    input  sw_pkg::score_t i_h_left,
    input  sw_pkg::score_t i_e_left,
    input  sw_pkg::score_t i_f_top,
    output sw_pkg::score_t o_h,
    output sw_pkg::score_t o_e,
    output sw_pkg::score_t o_f
);

    import sw_pkg::*;

    score_t sub_score;
    score_t h_sub;
    score_t e_open;
    score_t e_ext;
    score_t f_open;
    score_t f_ext;

    assign sub_score = (i_q_base == i_r_base) ? MATCH_SCORE : MISMATCH_SCORE;
    assign h_sub     = sat_add(i_h_diag, sub_score);

    // horizontal gap, coming from the left column
    assign e_open = sat_add(i_h_left, GAP_OPEN);
    assign e_ext  = sat_add(i_e_left, GAP_EXT);
    assign o_e    = smax(e_open, e_ext);

    // vertical gap, coming from the row above
    assign f_open = sat_add(i_h_top, GAP_OPEN);
    assign f_ext  = sat_add(i_f_top, GAP_EXT);
    assign o_f    = smax(f_open, f_ext);

    assign o_h = smax(h_sub, smax(o_e, o_f));

endmodule

// File: sw_pe_array.sv
module sw_pe_array #(
    parameter int N_PE = 8
) (
    input  logic                          i_clk,
    input  logic                          i_rst,
    input  logic                          i_start,
    input  logic                          i_q_valid,
    input  sw_pkg::base_e                 i_q_base,
    input  sw_pkg::base_e  [N_PE-1:0]     i_ref,
    input  logic           [N_PE-1:0]     i_active,
    output sw_pkg::score_t [N_PE-1:0]     o_h_vec
);

    import sw_pkg::*;

    base_e  q_reg [N_PE];
    base_e  r_reg [N_PE];
    score_t h_reg [N_PE];
    score_t e_reg [N_PE];
    score_t f_reg [N_PE];
    score_t h_dia [N_PE];

    // boundary penalty, GAP_OPEN + c * GAP_EXT at cycle c
    score_t bound_h;
    // cell has not yet seen its first query row
    logic [N_PE-1:0] fresh;

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            bound_h <= GAP_OPEN;
            fresh   <= '1;
        end else if (i_start) begin
            bound_h <= GAP_OPEN;
            fresh   <= '1;
        end else begin
            bound_h <= sat_add(bound_h, GAP_EXT);
            fresh   <= fresh & ~i_active;
        end
    end

    genvar j;
    generate
        for (j = 0; j < N_PE; j++) begin : g_cell
            score_t h_top_in;
            score_t f_top_in;
            score_t h_diag_in;
            score_t h_left_in;
            score_t e_left_in;
            score_t e_reg_nxt;
            score_t f_reg_nxt;

            // first row takes the top boundary
            assign h_top_in  = fresh[j] ? bound_h : h_reg[j];
            assign f_top_in  = fresh[j] ? NEG_INF : f_reg[j];

            if (j == 0) begin : g_first
                assign h_diag_in = h_dia[0];
                assign h_left_in = bound_h;
                assign e_left_in = NEG_INF;

                always_ff @(posedge i_clk) begin
                    if (i_q_valid) begin
                        q_reg[0] <= i_q_base;
                    end
                    // H(c-1, 0) for the row now at cell 0
                    if (i_start) begin
                        h_dia[0] <= '0;
                    end else begin
                        h_dia[0] <= bound_h;
                    end
                end
            end else begin : g_rest
                // first row diagonal from the stepped penalty
                assign h_diag_in = fresh[j] ? h_dia[0] : h_dia[j];
                assign h_left_in = h_reg[j-1];
                assign e_left_in = e_reg[j-1];

                always_ff @(posedge i_clk) begin
                    q_reg[j] <= q_reg[j-1];
                    if (i_active[j-1]) begin
                        h_dia[j] <= h_reg[j-1];
                    end
                end
            end

            sw_pe u_pe (
                .i_q_base (q_reg[j]),
                .i_r_base (r_reg[j]),
                .i_h_diag (h_diag_in),
                .i_h_top  (h_top_in),
                .i_h_left (h_left_in),
                .i_e_left (e_left_in),
                .i_f_top  (f_top_in),
                .o_h      (o_h_vec[j]),
                .o_e      (e_reg_nxt),
                .o_f      (f_reg_nxt)
            );

            always_ff @(posedge i_clk) begin
                if (i_start) begin
                    r_reg[j] <= i_ref[j];
                end
                if (i_active[j]) begin
                    h_reg[j] <= o_h_vec[j];
                    e_reg[j] <= e_reg_nxt;
                    f_reg[j] <= f_reg_nxt;
                end
            end
        end
    endgenerate

endmodule

// File: sw_max_tree.sv
module sw_max_tree #(
    parameter int N_PE = 8
) (
    input  sw_pkg::score_t [N_PE-1:0]      i_h_vec,
    input  logic           [N_PE-1:0]      i_active,
    output sw_pkg::score_t                 o_max,
    output logic           [$clog2(N_PE)-1:0] o_max_idx
);

    import sw_pkg::*;

    localparam int IDX_W  = $clog2(N_PE);
    localparam int LEAVES = 1 << IDX_W;

    // heap order, node k combines nodes 2k and 2k+1
    score_t           node_max [1:2*LEAVES-1];
    logic [IDX_W-1:0] node_idx [1:2*LEAVES-1];
    logic             node_ok  [1:2*LEAVES-1];
    logic             take_right;

    always_comb begin
        take_right = 1'b0;
        for (int i = 0; i < LEAVES; i++) begin
            node_idx[LEAVES+i] = IDX_W'(i);
            if (i < N_PE) begin
                node_ok[LEAVES+i]  = i_active[i];
                node_max[LEAVES+i] = i_active[i] ? i_h_vec[i] : NEG_INF;
            end else begin
                // padding leaves never win
                node_ok[LEAVES+i]  = 1'b0;
                node_max[LEAVES+i] = NEG_INF;
            end
        end

        // bottom level first, right child wins ties
        for (int k = LEAVES - 1; k >= 1; k--) begin
            take_right = node_ok[2*k+1] &&
                         (!node_ok[2*k] || (node_max[2*k+1] >= node_max[2*k]));
            if (take_right) begin
                node_max[k] = node_max[2*k+1];
                node_idx[k] = node_idx[2*k+1];
            end else begin
                node_max[k] = node_max[2*k];
                node_idx[k] = node_idx[2*k];
            end
            node_ok[k] = node_ok[2*k] || node_ok[2*k+1];
        end
    end

    assign o_max     = node_max[1];
    assign o_max_idx = node_idx[1];

endmodule

// File: sw_xdrop.sv
module sw_xdrop #(
    parameter int N_PE  = 8,
    parameter int XDROP = 20
) (
    input  logic                          i_clk,
    input  logic                          i_rst,
    input  logic                          i_start,
    input  logic                          i_diag_valid,
    input  logic [sw_pkg::POS_W-1:0]      i_cycle,
    input  sw_pkg::score_t                i_diag_max,
    input  logic [$clog2(N_PE)-1:0]       i_diag_idx,
    output logic                          o_stop,
    output sw_pkg::score_t                o_max_score,
    output logic [sw_pkg::POS_W-1:0]      o_max_row,
    output logic [sw_pkg::POS_W-1:0]      o_max_col,
    output logic                          o_early_stop
);

    import sw_pkg::*;

    logic [POS_W-1:0] row_now;
    logic [POS_W-1:0] col_now;
    // anti-diagonal stream was running last cycle without a stop
    logic             valid_d;

    assign col_now = POS_W'(i_diag_idx) + POS_W'(1);
    assign row_now = i_cycle - POS_W'(i_diag_idx) + POS_W'(1);

    // compared in int so the threshold cannot wrap below NEG_INF
    assign o_stop = i_diag_valid && (int'(i_diag_max) < (int'(o_max_score) - XDROP));

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            o_max_score  <= NEG_INF;
            o_max_row    <= '0;
            o_max_col    <= '0;
            o_early_stop <= 1'b0;
            valid_d      <= 1'b0;
        end else if (i_start) begin
            o_max_score <= NEG_INF;
            o_max_row   <= '0;
            o_max_col   <= '0;
            valid_d     <= 1'b0;
        end else begin
            valid_d <= i_diag_valid && !o_stop;
            // newer anti-diagonal wins a tie
            if (i_diag_valid && (i_diag_max >= o_max_score)) begin
                o_max_score <= i_diag_max;
                o_max_row   <= row_now;
                o_max_col   <= col_now;
            end
            // flag settles on the edge that ends the alignment
            if (o_stop) begin
                o_early_stop <= 1'b1;
            end else if (valid_d && !i_diag_valid) begin
                o_early_stop <= 1'b0;
            end
        end
    end

endmodule

// File: sw_ctrl.sv
module sw_ctrl #(
    parameter int N_PE = 8
) (
    input  logic                      i_clk,
    input  logic                      i_rst,
    input  logic                      i_q_valid,
    input  logic                      i_stop,
    output logic                      o_start,
    output logic [N_PE-1:0]           o_active,
    output logic                      o_diag_valid,
    output logic [sw_pkg::POS_W-1:0]  o_cycle,
    output logic                      o_busy,
    output logic                      o_done
);

    import sw_pkg::*;

    ctrl_state_e state;
    // query stream still delivering bases
    logic        q_open;
    // stream went idle since the last start
    logic        armed;
    logic        feed;

    assign o_start      = (state == ST_IDLE) && i_q_valid && armed;
    assign feed         = q_open && i_q_valid;
    assign o_diag_valid = (state == ST_CALC) && (|o_active);
    assign o_busy       = (state != ST_IDLE);
    assign o_done       = (state == ST_DONE);

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state    <= ST_IDLE;
            o_cycle  <= '0;
            o_active <= '0;
            q_open   <= 1'b0;
            armed    <= 1'b1;
        end else begin
            if (!i_q_valid) begin
                armed <= 1'b1;
            end
            case (state)
                ST_IDLE: begin
                    if (o_start) begin
                        state    <= ST_CALC;
                        o_cycle  <= '0;
                        o_active <= N_PE'(1);
                        q_open   <= 1'b1;
                        armed    <= 1'b0;
                    end
                end
                ST_CALC: begin
                    o_cycle <= o_cycle + POS_W'(1);
                    if (i_stop) begin
                        // later bases are dropped
                        state    <= ST_DONE;
                        o_active <= '0;
                        q_open   <= 1'b0;
                    end else begin
                        o_active <= {o_active[N_PE-2:0], feed};
                        q_open   <= feed;
                        if (!q_open && (o_active == '0)) begin
                            state <= ST_DONE;
                        end
                    end
                end
                ST_DONE: begin
                    state <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

// File: sw_top.sv
module sw_top #(
    parameter int N_PE  = 8,
    parameter int XDROP = 20
) (
    input  logic                          i_clk,
    input  logic                          i_rst,
    input  logic                          i_q_valid,
    input  sw_pkg::base_e                 i_q_base,
    input  sw_pkg::base_e [N_PE-1:0]      i_ref,
    output logic                          o_busy,
    output logic                          o_done,
    output sw_pkg::score_t                o_max_score,
    output logic [sw_pkg::POS_W-1:0]      o_max_row,
    output logic [sw_pkg::POS_W-1:0]      o_max_col,
    output logic                          o_early_stop
);

    import sw_pkg::*;

    logic                     start;
    logic                     stop;
    logic                     diag_valid;
    logic [N_PE-1:0]          active;
    logic [POS_W-1:0]         cycle;
    score_t [N_PE-1:0]        h_vec;
    score_t                   diag_max;
    logic [$clog2(N_PE)-1:0]  diag_idx;

    sw_ctrl #(
        .N_PE (N_PE)
    ) u_ctrl (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_q_valid    (i_q_valid),
        .i_stop       (stop),
        .o_start      (start),
        .o_active     (active),
        .o_diag_valid (diag_valid),
        .o_cycle      (cycle),
        .o_busy       (o_busy),
        .o_done       (o_done)
    );

    sw_pe_array #(
        .N_PE (N_PE)
    ) u_array (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_start   (start),
        .i_q_valid (i_q_valid),
        .i_q_base  (i_q_base),
        .i_ref     (i_ref),
        .i_active  (active),
        .o_h_vec   (h_vec)
    );

    sw_max_tree #(
        .N_PE (N_PE)
    ) u_tree (
        .i_h_vec   (h_vec),
        .i_active  (active),
        .o_max     (diag_max),
        .o_max_idx (diag_idx)
    );

    sw_xdrop #(
        .N_PE  (N_PE),
        .XDROP (XDROP)
    ) u_xdrop (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_start      (start),
        .i_diag_valid (diag_valid),
        .i_cycle      (cycle),
        .i_diag_max   (diag_max),
        .i_diag_idx   (diag_idx),
        .o_stop       (stop),
        .o_max_score  (o_max_score),
        .o_max_row    (o_max_row),
        .o_max_col    (o_max_col),
        .o_early_stop (o_early_stop)
    );

endmodule

// File: sw_top_sva.sv
module sw_top_sva (
    input logic i_clk,
    input logic i_rst,
    input logic i_busy,
    input logic i_done,
    input logic i_early_stop
);

    timeunit 1ns;
    timeprecision 1ps;

    // watched by the testbench
    int fail_count = 0;

    done_one_cycle: assert property (@(posedge i_clk) disable iff (i_rst)
        i_done |=> !i_done)
        else begin
            $error("o_done stayed high for more than one cycle");
            fail_count++;
        end

    // busy drops on the edge that ends the done cycle
    busy_falls_after_done: assert property (@(posedge i_clk) disable iff (i_rst)
        i_done |=> $fell(i_busy))
        else begin
            $error("o_busy did not fall at the end of o_done");
            fail_count++;
        end

    early_stop_at_done: assert property (@(posedge i_clk) disable iff (i_rst)
        $changed(i_early_stop) |-> i_done)
        else begin
            $error("o_early_stop changed outside of o_done");
            fail_count++;
        end

    done_while_busy: assert property (@(posedge i_clk) disable iff (i_rst)
        i_done |-> i_busy)
        else begin
            $error("o_done came while o_busy was low");
            fail_count++;
        end

endmodule

bind sw_top sw_top_sva u_sva (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_busy       (o_busy),
    .i_done       (o_done),
    .i_early_stop (o_early_stop)
);

// File: tb_sw_top.sv
module tb_sw_top;

    timeunit 1ns;
    timeprecision 1ps;

    import sw_pkg::*;

    localparam int N_PE       = 8;
    localparam int XDROP      = 20;
    localparam int MAX_L      = 40;
    localparam int N_RANDOM   = 40;
    localparam int WAIT_LIMIT = 200;

    logic             i_clk;
    logic             i_rst;
    logic             i_q_valid;
    base_e            i_q_base;
    base_e [N_PE-1:0] i_ref;
    logic             o_busy;
    logic             o_done;
    score_t           o_max_score;
    logic [POS_W-1:0] o_max_row;
    logic [POS_W-1:0] o_max_col;
    logic             o_early_stop;

    // query from row 1, reference from column 1
    base_e query [1:MAX_L];
    base_e refb  [1:N_PE];
    int    h_m   [0:MAX_L][0:N_PE];
    int    e_m   [0:MAX_L][0:N_PE];
    int    f_m   [0:MAX_L][0:N_PE];

    int    exp_score;
    int    exp_row;
    int    exp_col;
    int    exp_lat;
    logic  exp_early;
    int    early_count;

    initial i_clk = 1'b0;
    always #10 i_clk = ~i_clk;

    sw_top #(
        .N_PE  (N_PE),
        .XDROP (XDROP)
    ) u_sw_top (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_q_valid    (i_q_valid),
        .i_q_base     (i_q_base),
        .i_ref        (i_ref),
        .o_busy       (o_busy),
        .o_done       (o_done),
        .o_max_score  (o_max_score),
        .o_max_row    (o_max_row),
        .o_max_col    (o_max_col),
        .o_early_stop (o_early_stop)
    );

    function automatic int clamp_low(input int v);
        return (v < int'(NEG_INF)) ? int'(NEG_INF) : v;
    endfunction

    function automatic int larger(input int a, input int b);
        return (a >= b) ? a : b;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    always @(negedge i_clk) begin
        if (u_sw_top.u_sva.fail_count != 0) begin
            abort_run("a protocol assertion on the DUT outputs failed");
        end
    end

    task automatic check_score(input string name, input score_t exp, input score_t act);
        if (exp !== act) begin
            abort_run($sformatf("Fail %s expected %0d actual %0d", name, exp, act));
        end
    endtask

    task automatic check_pos(input string name, input logic [POS_W-1:0] exp,
                             input logic [POS_W-1:0] act);
        if (exp !== act) begin
            abort_run($sformatf("Fail %s expected %0d actual %0d", name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            abort_run($sformatf("Fail %s expected %0b actual %0b", name, exp, act));
        end
    endtask

    task automatic check_latency(input string name, input int exp, input int act);
        if (exp != act) begin
            abort_run($sformatf("Fail %s expected %0d actual %0d", name, exp, act));
        end
    endtask

    // Gotoh matrices, then an anti-diagonal scan in DUT cycle order
    task automatic compute_expected(input int len);
        int best;
        int dmax;
        int didx;
        int row;
        int s;
        bit found;
        h_m[0][0] = 0;
        e_m[0][0] = int'(NEG_INF);
        f_m[0][0] = int'(NEG_INF);
        for (int k = 1; k <= MAX_L; k++) begin
            h_m[k][0] = int'(GAP_OPEN) + (k - 1) * int'(GAP_EXT);
            e_m[k][0] = int'(NEG_INF);
            f_m[k][0] = int'(NEG_INF);
            if (k <= N_PE) begin
                h_m[0][k] = int'(GAP_OPEN) + (k - 1) * int'(GAP_EXT);
                e_m[0][k] = int'(NEG_INF);
                f_m[0][k] = int'(NEG_INF);
            end
        end
        for (int i = 1; i <= len; i++) begin
            for (int j = 1; j <= N_PE; j++) begin
                s = (query[i] == refb[j]) ? int'(MATCH_SCORE) : int'(MISMATCH_SCORE);
                e_m[i][j] = larger(clamp_low(h_m[i][j-1] + int'(GAP_OPEN)),
                                   clamp_low(e_m[i][j-1] + int'(GAP_EXT)));
                f_m[i][j] = larger(clamp_low(h_m[i-1][j] + int'(GAP_OPEN)),
                                   clamp_low(f_m[i-1][j] + int'(GAP_EXT)));
                h_m[i][j] = larger(clamp_low(h_m[i-1][j-1] + s),
                                   larger(e_m[i][j], f_m[i][j]));
            end
        end
        best      = int'(NEG_INF);
        exp_row   = 0;
        exp_col   = 0;
        exp_early = 1'b0;
        exp_lat   = len + N_PE;
        for (int c = 0; c <= len + N_PE - 2; c++) begin
            found = 1'b0;
            dmax  = int'(NEG_INF);
            didx  = 0;
            // higher cell index wins a tie
            for (int j = 0; j < N_PE; j++) begin
                row = c - j + 1;
                if (row >= 1 && row <= len) begin
                    if (!found || h_m[row][j+1] >= dmax) begin
                        dmax  = h_m[row][j+1];
                        didx  = j;
                        found = 1'b1;
                    end
                end
            end
            if (dmax < best - XDROP) begin
                exp_early = 1'b1;
                exp_lat   = c + 1;
                break;
            end
            if (dmax >= best) begin
                best    = dmax;
                exp_row = c - didx + 1;
                exp_col = didx + 1;
            end
        end
        exp_score = best;
    endtask

    task automatic check_results(input string name);
        check_score({name, " score"}, score_t'(exp_score), o_max_score);
        check_pos({name, " row"}, POS_W'(exp_row), o_max_row);
        check_pos({name, " col"}, POS_W'(exp_col), o_max_col);
        check_flag({name, " early stop"}, exp_early, o_early_stop);
    endtask

    task automatic fill_random(input int len);
        for (int j = 1; j <= N_PE; j++) begin
            refb[j] = base_e'($urandom_range(0, 3));
        end
        for (int i = 1; i <= len; i++) begin
            query[i] = base_e'($urandom_range(0, 3));
        end
    endtask

    // streams query[1..len] against refb and checks result and latency
    task automatic run_alignment(input string name, input int len);
        int n;
        int lat;
        bit done_seen;
        compute_expected(len);
        @(negedge i_clk);
        i_q_valid = 1'b0;
        n = 0;
        while (o_busy) begin
            @(negedge i_clk);
            n++;
            if (n > WAIT_LIMIT) begin
                abort_run($sformatf("%s: the DUT stayed busy and never went idle", name));
            end
        end
        // idle cycle so the controller can arm again
        @(negedge i_clk);
        for (int j = 0; j < N_PE; j++) begin
            i_ref[j] = refb[j+1];
        end
        i_q_valid = 1'b1;
        i_q_base  = query[1];
        done_seen = 1'b0;
        lat       = 0;
        n         = 0;
        while (!done_seen || n < len) begin
            @(negedge i_clk);
            n++;
            if (n < len) begin
                i_q_base = query[n+1];
            end else begin
                i_q_valid = 1'b0;
                i_q_base  = base_e'($urandom_range(0, 3));
            end
            if (o_done && !done_seen) begin
                done_seen = 1'b1;
                lat       = n - 1;
                check_results(name);
                check_latency({name, " latency"}, exp_lat, lat);
            end
            if (!done_seen && n > len + N_PE + 4) begin
                abort_run($sformatf("%s: done never came after the query", name));
            end
        end
        // late bases must leave the result alone
        check_results({name, " hold"});
    endtask

    initial begin
        void'($urandom(49));
        early_count = 0;
        i_rst       = 1'b1;
        i_q_valid   = 1'b0;
        i_q_base    = BASE_A;
        for (int j = 0; j < N_PE; j++) begin
            i_ref[j] = BASE_A;
        end
        repeat (8) @(posedge i_clk);
        @(negedge i_clk);
        i_rst = 1'b0;
        @(negedge i_clk);
        check_flag("reset busy", 1'b0, o_busy);
        check_flag("reset done", 1'b0, o_done);
        check_flag("reset early stop", 1'b0, o_early_stop);
        check_score("reset score", NEG_INF, o_max_score);

        // query equal to the reference
        fill_random(N_PE);
        for (int i = 1; i <= N_PE; i++) begin
            query[i] = refb[i];
        end
        run_alignment("identical", N_PE);
        check_score("identical fixed score", score_t'(N_PE * int'(MATCH_SCORE)), o_max_score);
        check_pos("identical fixed row", POS_W'(N_PE), o_max_row);
        check_pos("identical fixed col", POS_W'(N_PE), o_max_col);
        check_flag("identical fixed early stop", 1'b0, o_early_stop);

        for (int t = 0; t < N_RANDOM; t++) begin
            int len;
            len = $urandom_range(1, MAX_L);
            fill_random(len);
            run_alignment($sformatf("random %0d", t), len);
            if (exp_early) begin
                early_count++;
            end
        end
        $display("random alignments that stopped early: %0d of %0d", early_count, N_RANDOM);

        // one matching base, an inserted run, then the rest of the reference
        for (int ins = 1; ins <= 3; ins++) begin
            fill_random(N_PE + ins);
            query[1] = refb[1];
            for (int i = 2; i <= N_PE; i++) begin
                query[i + ins] = refb[i];
            end
            run_alignment($sformatf("insert %0d", ins), N_PE + ins);
        end

        // all mismatches, stops early while bases keep coming
        for (int j = 1; j <= N_PE; j++) begin
            refb[j] = BASE_A;
        end
        for (int i = 1; i <= 30; i++) begin
            query[i] = BASE_T;
        end
        run_alignment("mismatch stop", 30);
        if (!exp_early) begin
            abort_run("the all-mismatch alignment was expected to stop early but did not");
        end
        fill_random(20);
        run_alignment("after stop", 20);

        repeat (4) @(negedge i_clk);
        if (u_sw_top.u_sva.fail_count == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            abort_run("a protocol assertion on the DUT outputs failed");
        end
    end

endmodule

// File: verilog.f
sw_pkg.sv
sw_pe.sv
sw_pe_array.sv
sw_max_tree.sv
sw_xdrop.sv
sw_ctrl.sv
sw_top.sv
sw_top_sva.sv
tb_sw_top.sv

// File: Bender.yml
package:
  name: sw_aligner

sources:
  - sw_pkg.sv
  - sw_pe.sv
  - sw_pe_array.sv
  - sw_max_tree.sv
  - sw_xdrop.sv
  - sw_ctrl.sv
  - sw_top.sv
  - target: test
    files:
      - sw_top_sva.sv
      - tb_sw_top.sv
